// ==== testbench/program.hex ====
// One 32-bit instruction word per line, word 0 first.
// Bits 5:0 are the opcode, bits 31:6 the signed word offset of a jump.
00000A10
00000B11
12345620
000000C1 // OP_JMP +3
DEADBE05
DEADBE06
00C0FF3F
00000102 // OP_JMPL +4
BAD00008
BAD00009
BAD0000A
0ABCDE00
FFFFFF00
FFFFFCC1 // OP_JMP -13
5555550E
5555550F
10000010
000000C3 // OP_BT +3
20000012
30000013
00000104 // OP_BF +4
40000015
50000016
60000017
70000018
FFFFFDC1 // OP_JMP -9
8000001A
9000001B
A000001C
B000001D
C000001E
D000001F

// ==== files.f ====
rtl/ncpu32k_pkg.sv
rtl/ncpu32k_ipdu.sv
rtl/ncpu32k_pipebuf.sv
rtl/ncpu32k_imem.sv
rtl/ncpu32k_ifu.sv
rtl/ncpu32k_fetch_top.sv
testbench/tb_fetch_top.sv

// ==== Makefile ====
TOP = tb_fetch_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f

# The memory model loads program.hex from the working directory.
run: compile
	cp testbench/program.hex program.hex
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir program.hex

// ==== testbench/tb_fetch_top.sv ====
/* Directed testbench for the fetch subsystem, with a model of the
   fetch stream and typed compare tasks. */

`timescale 1ns/1ps

module tb_fetch_top;

   // Cycles allowed for any single item to reach decode.
   localparam int ITEM_TIMEOUT = 20;

   logic                  clk;
   logic                  reset;
   logic                  jmpfar;
   ncpu32k_pkg::pc_t      jmpfar_addr;
   logic                  cc;
   logic                  idu_valid;
   logic                  idu_ready;
   ncpu32k_pkg::idu_out_t idu_out;

   // Copy of the program image for the model.
   ncpu32k_pkg::insn_t prog [0:ncpu32k_pkg::IMEM_DEPTH-1];

   // Word address that decode should accept next.
   ncpu32k_pkg::pc_t exp_pc;

   integer seed;
   int     errors;
   int     checks;
   int     tests_run;
   int     tests_failed;
   int     errors_at_start;
   int     n_jmp;
   int     n_jmpl;
   int     n_bt_taken;
   int     n_bt_not;
   int     n_bf_taken;
   int     n_bf_not;

   ncpu32k_fetch_top DUT (
      .clk         (clk),
      .reset       (reset),
      .jmpfar      (jmpfar),
      .jmpfar_addr (jmpfar_addr),
      .cc          (cc),
      .idu_valid   (idu_valid),
      .idu_ready   (idu_ready),
      .idu_out     (idu_out)
   );

   always #2 clk = ~clk;

   // A word is a taken jump when its opcode is one of the two plain jumps,
   // or a branch whose condition matches the flag.
   function automatic logic is_taken(ncpu32k_pkg::insn_t insn, logic flag);
      ncpu32k_pkg::opcode_t op;
      op = insn[5:0];
      return (op == ncpu32k_pkg::OP_JMP) || (op == ncpu32k_pkg::OP_JMPL) ||
             ((op == ncpu32k_pkg::OP_BT) && flag) || ((op == ncpu32k_pkg::OP_BF) && !flag);
   endfunction

   // Signed word offset from bits 31:6, widened to the PC width.
   function automatic ncpu32k_pkg::pc_t jump_offset(ncpu32k_pkg::insn_t insn);
      return ncpu32k_pkg::pc_t'($signed(insn[31:6]));
   endfunction

   // Successor of a word in the fetch stream, wrapping modulo 2**30.
   function automatic ncpu32k_pkg::pc_t model_next(ncpu32k_pkg::pc_t pc, logic flag);
      ncpu32k_pkg::insn_t insn;
      insn = prog[pc[ncpu32k_pkg::IMEM_AW-1:0]];
      if (is_taken(insn, flag)) begin
         return pc + jump_offset(insn);
      end
      return pc + ncpu32k_pkg::pc_t'(1);
   endfunction

   // Item decode should see for a word address.
   function automatic ncpu32k_pkg::idu_out_t expected_item(ncpu32k_pkg::pc_t pc);
      ncpu32k_pkg::idu_out_t item;
      ncpu32k_pkg::opcode_t  op;
      item.insn        = prog[pc[ncpu32k_pkg::IMEM_AW-1:0]];
      op               = item.insn[5:0];
      item.pc          = pc;
      item.op_jmprel   = (op >= ncpu32k_pkg::OP_JMP) && (op <= ncpu32k_pkg::OP_BF);
      item.jmprel_link = (op == ncpu32k_pkg::OP_JMPL);
      return item;
   endfunction

   function automatic string item_text(ncpu32k_pkg::idu_out_t it);
      return $sformatf("insn=%h pc=%h jmprel=%b link=%b",
                       it.insn, it.pc, it.op_jmprel, it.jmprel_link);
   endfunction

   task automatic check_item(input string name, input ncpu32k_pkg::idu_out_t exp,
                             input ncpu32k_pkg::idu_out_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s expected %s actual %s", name, item_text(exp), item_text(act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic fail_note(input string name, input string msg);
      errors++;
      $display("ERROR %s: %s", name, msg);
   endtask

   // Count the control-flow words that reached decode.
   task automatic tally(input ncpu32k_pkg::insn_t insn);
      case (insn[5:0])
         ncpu32k_pkg::OP_JMP:  n_jmp++;
         ncpu32k_pkg::OP_JMPL: n_jmpl++;
         ncpu32k_pkg::OP_BT: begin
            if (cc) begin
               n_bt_taken++;
            end else begin
               n_bt_not++;
            end
         end
         ncpu32k_pkg::OP_BF: begin
            if (cc) begin
               n_bf_not++;
            end else begin
               n_bf_taken++;
            end
         end
         default: ;
      endcase
   endtask

   // Wait for one transfer to decode. Outputs are sampled at the falling
   // edge, and a new idu_ready is driven just after each rising edge.
   task automatic take_item(input string name, input bit rand_ready,
                            output ncpu32k_pkg::idu_out_t item, output int waited,
                            output bit ok);
      integer r;
      bit     took;
      ok     = 1'b0;
      waited = 0;
      item   = '0;
      while (!ok && waited < ITEM_TIMEOUT) begin
         if (rand_ready) begin
            r         = $random(seed);
            idu_ready = r[0];
         end
         @(negedge clk);
         took = idu_valid & idu_ready;
         item = idu_out;
         @(posedge clk);
         #1;
         waited++;
         ok = took;
      end
      if (!ok) begin
         fail_note(name, $sformatf("no item accepted within %0d cycles", ITEM_TIMEOUT));
      end
   endtask

   // Accept count items and hold each one against the model.
   task automatic run_stream(input string name, input int count, input bit rand_ready);
      ncpu32k_pkg::idu_out_t item;
      int                    waited;
      bit                    ok;
      ok = 1'b1;
      for (int i = 0; i < count && ok; i++) begin
         take_item(name, rand_ready, item, waited, ok);
         if (ok) begin
            // With idu_ready held high there must be one item per cycle.
            if (!rand_ready && i > 0 && waited != 1) begin
               fail_note(name, "stream stalled while idu_ready was held high");
            end
            check_item(name, expected_item(exp_pc), item);
            tally(item.insn);
            exp_pc = model_next(exp_pc, cc);
         end
      end
   endtask

   // One-cycle far jump, with decode stalled so nothing transfers in it.
   task automatic far_jump(input ncpu32k_pkg::pc_t target, input logic new_cc);
      jmpfar      = 1'b1;
      jmpfar_addr = target;
      cc          = new_cc;
      idu_ready   = 1'b0;
      @(posedge clk);
      #1;
      jmpfar    = 1'b0;
      idu_ready = 1'b1;
      exp_pc    = target;
   endtask

   task automatic begin_test();
      errors_at_start = errors;
      n_jmp      = 0;
      n_jmpl     = 0;
      n_bt_taken = 0;
      n_bt_not   = 0;
      n_bf_taken = 0;
      n_bf_not   = 0;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errors - errors_at_start);
      end
   endtask

   task automatic test_reset();
      ncpu32k_pkg::idu_out_t item;
      bit                    got;
      int                    cycles;
      begin_test();
      @(posedge clk);
      @(negedge clk);
      check_flag("reset valid", 1'b0, idu_valid);
      @(posedge clk);
      #1;
      reset     = 1'b0;
      idu_ready = 1'b1;
      got       = 1'b0;
      cycles    = 0;
      // Decode stays idle, with zeroed fields, until the first word arrives.
      while (!got && cycles < ITEM_TIMEOUT) begin
         @(negedge clk);
         if (idu_valid === 1'b1) begin
            got  = 1'b1;
            item = idu_out;
         end else begin
            check_flag("reset idle valid", 1'b0, idu_valid);
            check_flag("reset idle insn", 1'b1, idu_out.insn == '0);
            check_flag("reset idle jmprel", 1'b0, idu_out.op_jmprel);
            check_flag("reset idle link", 1'b0, idu_out.jmprel_link);
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      if (got) begin
         check_item("reset first item", expected_item(ncpu32k_pkg::RESET_PC), item);
         exp_pc = model_next(ncpu32k_pkg::RESET_PC, cc);
      end else begin
         fail_note("reset", "no item reached decode after reset");
      end
      end_test("reset");
   endtask

   task automatic test_sequential();
      begin_test();
      run_stream("sequential", 12, 1'b0);
      end_test("sequential");
   endtask

   task automatic test_rel_jumps();
      begin_test();
      run_stream("rel_jumps", 10, 1'b0);
      if (n_jmp == 0 || n_jmpl == 0) begin
         fail_note("rel_jumps", "stream never reached both OP_JMP and OP_JMPL");
      end
      end_test("rel_jumps");
   endtask

   task automatic test_branches();
      begin_test();
      far_jump(ncpu32k_pkg::pc_t'(16), 1'b1);
      run_stream("branches cc=1", 14, 1'b0);
      far_jump(ncpu32k_pkg::pc_t'(16), 1'b0);
      run_stream("branches cc=0", 14, 1'b0);
      if (n_bt_taken == 0 || n_bf_not == 0 || n_bt_not == 0 || n_bf_taken == 0) begin
         fail_note("branches", "branch words were not seen under both flag values");
      end
      end_test("branches");
   endtask

   task automatic test_backpressure();
      begin_test();
      run_stream("backpressure", 40, 1'b1);
      end_test("backpressure");
   endtask

   task automatic test_far_jump();
      ncpu32k_pkg::pc_t held_pc;
      begin_test();
      idu_ready = 1'b1;
      run_stream("far_jump before", 3, 1'b0);
      // The buffer now holds the next model item, which the jump flushes.
      held_pc = exp_pc;
      // Target region near the top of memory, so the stream wraps past word 31.
      far_jump(ncpu32k_pkg::pc_t'(26), cc);
      // Right after the flush decode is idle, the fields read zero and
      // the pc still shows the flushed item.
      @(negedge clk);
      check_flag("far_jump idle valid", 1'b0, idu_valid);
      check_flag("far_jump idle insn", 1'b1, idu_out.insn == '0);
      check_flag("far_jump idle pc", 1'b1, idu_out.pc == held_pc);
      run_stream("far_jump after", 10, 1'b0);
      end_test("far_jump");
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      jmpfar      = 1'b0;
      jmpfar_addr = '0;
      cc          = 1'b0;
      idu_ready   = 1'b0;
      seed        = 48;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      tests_failed = 0;
      exp_pc      = ncpu32k_pkg::RESET_PC;
      $readmemh("testbench/program.hex", prog);

      test_reset();
      test_sequential();
      test_rel_jumps();
      test_branches();
      test_backpressure();
      test_far_jump();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== rtl/ncpu32k_fetch_top.sv ====
/* Top level of the fetch subsystem joining the instruction memory
   and the fetch unit. */

`timescale 1ns/1ps

module ncpu32k_fetch_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  jmpfar,
   input  ncpu32k_pkg::pc_t      jmpfar_addr,
   input  logic                  cc,
   output logic                  idu_valid,
   input  logic                  idu_ready,
   output ncpu32k_pkg::idu_out_t idu_out
);

   // Bus between the memory and the fetch unit.
   logic                   fetch_en;
   logic                   ibus_valid;
   logic                   ibus_ready;
   ncpu32k_pkg::ibus_rsp_t ibus_rsp;
   ncpu32k_pkg::addr_t     ibus_addr;

   ncpu32k_imem u_imem (
      .clk       (clk),
      .reset     (reset),
      .fetch_en  (fetch_en),
      .addr      (ibus_addr),
      .rsp_valid (ibus_valid),
      .rsp_ready (ibus_ready),
      .rsp       (ibus_rsp)
   );

   // The fetch unit drives decode directly, with no extra stage here.
   ncpu32k_ifu u_ifu (
      .clk         (clk),
      .reset       (reset),
      .fetch_en    (fetch_en),
      .ibus_valid  (ibus_valid),
      .ibus_ready  (ibus_ready),
      .ibus_rsp    (ibus_rsp),
      .ibus_addr   (ibus_addr),
      .jmpfar      (jmpfar),
      .jmpfar_addr (jmpfar_addr),
      .cc          (cc),
      .idu_valid   (idu_valid),
      .idu_ready   (idu_ready),
      .idu_out     (idu_out)
   );

endmodule

// ==== rtl/ncpu32k_ifu.sv ====
/* Instruction fetch unit with warm-up counter, restart PC,
   next-address selection, predecode and the decode-side buffer. */

`timescale 1ns/1ps

module ncpu32k_ifu (
   input  logic                   clk,
   input  logic                   reset,
   output logic                   fetch_en,
   input  logic                   ibus_valid,
   output logic                   ibus_ready,
   input  ncpu32k_pkg::ibus_rsp_t ibus_rsp,
   output ncpu32k_pkg::addr_t     ibus_addr,
   input  logic                   jmpfar,
   input  ncpu32k_pkg::pc_t       jmpfar_addr,
   input  logic                   cc,
   output logic                   idu_valid,
   input  logic                   idu_ready,
   output ncpu32k_pkg::idu_out_t  idu_out
);

   ncpu32k_pkg::warmup_cnt_t warmup_cnt;
   ncpu32k_pkg::pc_t         restart_pc;
   ncpu32k_pkg::pc_t         next_pc;
   ncpu32k_pkg::pc_t         jmprel_offset;
   logic                     op_jmprel;
   logic                     jmprel_link;
   logic                     jmprel_taken;
   logic                     buf_in_valid;
   logic                     buf_in_ready;
   logic                     buf_out_valid;
   ncpu32k_pkg::idu_out_t    buf_din;
   ncpu32k_pkg::idu_out_t    buf_dout;

   // Warm-up counter.
   // It counts up after reset and parks at WARMUP_CYCLES, which enables
   // fetch on the second clock edge after reset is released.
   always_ff @(posedge clk) begin
      if (reset) begin
         warmup_cnt <= '0;
      end else if (~fetch_en) begin
         warmup_cnt <= warmup_cnt + 1'b1;
      end
   end

   assign fetch_en =
      (warmup_cnt == ncpu32k_pkg::warmup_cnt_t'(ncpu32k_pkg::WARMUP_CYCLES));

   // Restart PC.
   // It supplies the fetch address whenever no response is on the bus,
   // which covers the first read after reset and reads after a far jump.
   always_ff @(posedge clk) begin
      if (reset) begin
         restart_pc <= ncpu32k_pkg::RESET_PC;
      end else if (jmpfar) begin
         restart_pc <= jmpfar_addr;
      end
   end

   // Predecode the word presented by the memory.
   ncpu32k_ipdu u_ipdu (
      .insn          (ibus_rsp.insn),
      .cc            (cc),
      .op_jmprel     (op_jmprel),
      .jmprel_link   (jmprel_link),
      .jmprel_taken  (jmprel_taken),
      .jmprel_offset (jmprel_offset)
   );

   // Next fetch address, first matching case wins.
   // A far jump overrides everything, then a taken relative jump, then
   // the sequential successor of the presented word.
   always_comb begin
      if (jmpfar) begin
         next_pc = jmpfar_addr;
      end else if (ibus_valid & jmprel_taken) begin
         next_pc = ibus_rsp.id + jmprel_offset;
      end else if (ibus_valid) begin
         next_pc = ibus_rsp.id + 1'b1;
      end else begin
         next_pc = restart_pc;
      end
   end

   // Word address to byte address.
   assign ibus_addr = {next_pc, 2'b00};

   // A far jump forces the response to be taken so that the memory slot
   // frees up and the target is read in the same cycle.
   // Otherwise the bus advances only when the buffer has room.
   assign ibus_ready = jmpfar | (fetch_en & buf_in_ready);

   // The response taken during a far jump is dropped here.
   assign buf_in_valid = ibus_valid & ~jmpfar;

   // Item for decode, built from the response and its predecode flags.
   always_comb begin
      buf_din.insn        = ibus_rsp.insn;
      buf_din.pc          = ibus_rsp.id;
      buf_din.op_jmprel   = op_jmprel;
      buf_din.jmprel_link = jmprel_link;
   end

   // Buffer toward decode.
   // The far jump flushes whatever older item it holds.
   ncpu32k_pipebuf u_pipebuf (
      .clk       (clk),
      .reset     (reset),
      .flush     (jmpfar),
      .in_valid  (buf_in_valid),
      .in_ready  (buf_in_ready),
      .din       (buf_din),
      .out_valid (buf_out_valid),
      .out_ready (idu_ready),
      .dout      (buf_dout)
   );

   assign idu_valid = buf_out_valid;

   // Decode sees zeros when nothing is valid, except for the pc, which
   // keeps showing the last item that passed through.
   always_comb begin
      idu_out.insn        = buf_dout.insn & {ncpu32k_pkg::IW{buf_out_valid}};
      idu_out.pc          = buf_dout.pc;
      idu_out.op_jmprel   = buf_dout.op_jmprel & buf_out_valid;
      idu_out.jmprel_link = buf_dout.jmprel_link & buf_out_valid;
   end

endmodule

// ==== rtl/ncpu32k_imem.sv ====
/* Synchronous instruction memory with a single registered response slot,
   loaded from the program image. */

`timescale 1ns/1ps

module ncpu32k_imem (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   fetch_en,
   input  ncpu32k_pkg::addr_t     addr,
   output logic                   rsp_valid,
   input  logic                   rsp_ready,
   output ncpu32k_pkg::ibus_rsp_t rsp
);

   ncpu32k_pkg::insn_t     mem [0:ncpu32k_pkg::IMEM_DEPTH-1];
   ncpu32k_pkg::pc_t       word_addr;
   logic                   slot_valid;
   ncpu32k_pkg::ibus_rsp_t slot_q;
   logic                   issue;

   // Program image, shared with the testbench.
   initial begin
      $readmemh("program.hex", mem);
   end

   // Byte address to word address.
   assign word_addr = addr[ncpu32k_pkg::AW-1:2];

   // A read goes out whenever fetch is on and the slot is free, or is
   // being emptied by the fetch unit in this cycle.
   assign issue = fetch_en & (~slot_valid | rsp_ready);

   always_ff @(posedge clk) begin
      if (reset) begin
         slot_valid <= 1'b0;
      end else if (issue) begin
         slot_valid <= 1'b1;
      end else if (rsp_ready) begin
         slot_valid <= 1'b0;
      end
   end

   // The slot captures the word and the full word address it came from.
   // Only the low index bits select the word, so addresses wrap around.
   always_ff @(posedge clk) begin
      if (issue) begin
         slot_q.insn <= mem[word_addr[ncpu32k_pkg::IMEM_AW-1:0]];
         slot_q.id   <= word_addr;
      end
   end

   assign rsp_valid = slot_valid;
   assign rsp       = slot_q;

endmodule

// ==== rtl/ncpu32k_pipebuf.sv ====
/* One-entry valid/ready pipeline buffer with flush. */

`timescale 1ns/1ps

module ncpu32k_pipebuf (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  flush,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  ncpu32k_pkg::idu_out_t din,
   output logic                  out_valid,
   input  logic                  out_ready,
   output ncpu32k_pkg::idu_out_t dout
);

   logic                  valid_q;
   ncpu32k_pkg::idu_out_t data_q;
   logic                  load;

   // The stage can accept a new item when it is empty, or when the item
   // it holds leaves in this same cycle.
   assign in_ready = ~valid_q | out_ready;
   assign load     = in_valid & in_ready;

   // Flush wins over a load so that nothing fetched before a redirect
   // survives into the next cycle.
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (flush) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end else if (out_ready) begin
         valid_q <= 1'b0;
      end
   end

   // Payload register.
   // It keeps its old contents when nothing is loaded, so the pc of the
   // last item stays visible downstream.
   always_ff @(posedge clk) begin
      if (load & ~flush) begin
         data_q <= din;
      end
   end

   assign out_valid = valid_q;
   assign dout      = data_q;

endmodule

// ==== rtl/ncpu32k_ipdu.sv ====
/* Predecoder that classifies an instruction word and resolves
   PC-relative jumps against the condition flag. */

`timescale 1ns/1ps

module ncpu32k_ipdu (
   input  ncpu32k_pkg::insn_t insn,
   input  logic               cc,
   output logic               op_jmprel,
   output logic               jmprel_link,
   output logic               jmprel_taken,
   output ncpu32k_pkg::pc_t   jmprel_offset
);

   ncpu32k_pkg::opcode_t opc;

   // The opcode field occupies the lowest bits of the word.
   assign opc = insn[ncpu32k_pkg::OPC_W-1:0];

   // Classify the opcode.
   // Conditional branches look at the flag that is current while the
   // response is presented on the bus.
   always_comb begin
      op_jmprel    = 1'b0;
      jmprel_link  = 1'b0;
      jmprel_taken = 1'b0;
      case (opc)
         ncpu32k_pkg::OP_JMP: begin
            op_jmprel    = 1'b1;
            jmprel_taken = 1'b1;
         end
         ncpu32k_pkg::OP_JMPL: begin
            // Same as a plain jump, but decode must also write the link.
            op_jmprel    = 1'b1;
            jmprel_link  = 1'b1;
            jmprel_taken = 1'b1;
         end
         ncpu32k_pkg::OP_BT: begin
            op_jmprel    = 1'b1;
            jmprel_taken = cc;
         end
         ncpu32k_pkg::OP_BF: begin
            op_jmprel    = 1'b1;
            jmprel_taken = ~cc;
         end
         default: begin
            // Plain instruction, fetch continues sequentially.
            op_jmprel    = 1'b0;
         end
      endcase
   end

   // The offset is a signed word count in the upper bits of the insn.
   // It is sign-extended to the PC width so the adder wraps naturally.
   assign jmprel_offset = {
      {(ncpu32k_pkg::PCW - ncpu32k_pkg::OFFSET_W){insn[ncpu32k_pkg::IW-1]}},
      insn[ncpu32k_pkg::IW-1:ncpu32k_pkg::OPC_W]
   };

endmodule

// ==== rtl/ncpu32k_pkg.sv ====
/* Shared widths, vector typedefs, opcodes, memory and reset constants,
   and the packed structs of the fetch subsystem. */

package ncpu32k_pkg;

   // Instruction and address widths.
   // The PC counts 32-bit words, so it drops the two byte-offset bits.
   localparam int IW  = 32;
   localparam int AW  = 32;
   localparam int PCW = AW - 2;

   // The opcode sits in the low bits of the instruction word.
   // The relative jump offset fills the remaining upper bits.
   localparam int OPC_W    = 6;
   localparam int OFFSET_W = IW - OPC_W;

   typedef logic [IW-1:0]    insn_t;
   typedef logic [AW-1:0]    addr_t;
   typedef logic [PCW-1:0]   pc_t;
   typedef logic [OPC_W-1:0] opcode_t;

   // Relative jump opcodes recognised by the predecoder.
   // Every other opcode is treated as a plain instruction.
   localparam opcode_t OP_JMP  = 6'd1;
   localparam opcode_t OP_JMPL = 6'd2;
   localparam opcode_t OP_BT   = 6'd3;
   localparam opcode_t OP_BF   = 6'd4;

   // Instruction memory geometry.
   // Only the low IMEM_AW bits of the word address select a word.
   localparam int IMEM_AW    = 5;
   localparam int IMEM_DEPTH = 1 << IMEM_AW;

   // Fetch starts at word 0 after reset.
   localparam pc_t RESET_PC = '0;

   // Number of cycles the warm-up counter runs before fetch is enabled.
   localparam int WARMUP_CYCLES = 2;
   localparam int WARMUP_CW     = 2;

   typedef logic [WARMUP_CW-1:0] warmup_cnt_t;

   // Response of the instruction memory.
   // The id is the word address the instruction was read from.
   typedef struct packed {
      insn_t insn;
      pc_t   id;
   } ibus_rsp_t;

   // Item handed to decode, with the predecode flags attached.
   typedef struct packed {
      insn_t insn;
      pc_t   pc;
      logic  op_jmprel;
      logic  jmprel_link;
   } idu_out_t;

endpackage
